/* verilog/cam_bist_pkg.sv */
// ====================================================================
// Shared types for the CAM BIST subsystem
// Struct fields are sized by MAX_ENTRIES and MAX_DWIDTH, so the
// module parameters ENTRIES and DWIDTH must not exceed them
// key_of assumes DWIDTH > AWIDTH so the inverse part is present
// ====================================================================
package cam_bist_pkg;

  // Upper bounds for the command struct fields
  localparam int MAX_ENTRIES = 256;
  localparam int MAX_DWIDTH  = 64;

  typedef logic [$clog2(MAX_ENTRIES)-1:0] addr_t;
  typedef logic [MAX_DWIDTH-1:0]          key_t;

  typedef enum logic [1:0] {
    OP_IDLE   = 2'b00,
    OP_WRITE  = 2'b01,
    OP_READ   = 2'b10,
    OP_SEARCH = 2'b11
  } cam_op_e;

  // Expected match select, same coding as the BIST sel1/sel0 pair
  typedef enum logic [1:0] {
    SEL_ALL_MATCH       = 2'b00,
    SEL_SINGLE_MATCH    = 2'b01,
    SEL_SINGLE_MISMATCH = 2'b10,
    SEL_ALL_MISMATCH    = 2'b11
  } match_sel_e;

  typedef enum logic {
    ALGO_MARCH   = 1'b0,
    ALGO_COMPARE = 1'b1
  } bist_algo_e;

  // One command to the CAM; key is write data and search key alike
  typedef struct packed {
    cam_op_e    op;
    addr_t      addr;
    key_t       key;
    logic       cm_mode;
    match_sel_e match_sel;
  } cam_cmd_t;

  // Unique key per address
  // Address in the low bits, its inverse repeated above up to dwidth
  function automatic key_t key_of(input addr_t addr, input int awidth, input int dwidth);
    key_t key;
    key = '0;
    for (int i = 0; i < MAX_DWIDTH; i++) begin
      if (i < awidth) begin
        key[i] = addr[i];
      end else if (i < dwidth) begin
        key[i] = ~addr[i % awidth];
      end
    end
    return key;
  endfunction

endpackage

/* verilog/cam_bist_sequencer.sv */
// ====================================================================
// BIST sequencer for the CAM
// One command per cycle, registered; two idle cycles after each phase
// match_sel and cm_mode stay constant through a phase and its gap,
// since the output handler samples them without delay
// A start is taken only in idle with busy low
// ====================================================================
`timescale 1ns/10ps

module cam_bist_sequencer #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH  = 12,
  parameter int AWIDTH  = 4
) (
  input  logic                     bist_clk,
  input  logic                     rst,
  input  logic                     bist_start,
  input  cam_bist_pkg::bist_algo_e algo,
  output cam_bist_pkg::cam_cmd_t   cmd,
  output logic                     busy,
  output logic                     last_issued
);

  typedef enum logic [3:0] {
    S_IDLE,
    S_WR_KEY,
    S_SRCH_KEY,
    S_RD_KEY,
    S_WR_BG,
    S_SRCH_BG,
    S_SRCH_INV,
    S_WALK,
    S_GAP
  } state_e;

  // Background is all zero, its inverse all one within DWIDTH
  localparam cam_bist_pkg::key_t KEY_BG  = '0;
  localparam cam_bist_pkg::key_t KEY_INV = cam_bist_pkg::key_t'({DWIDTH{1'b1}});
  localparam logic [AWIDTH-1:0]  LAST_ADDR = AWIDTH'(ENTRIES - 1);

  state_e                   state;
  state_e                   after_gap;
  state_e                   next_phase;
  cam_bist_pkg::bist_algo_e algo_q;
  logic [AWIDTH-1:0]        addr_cnt;
  logic [1:0]               step;
  logic                     gap_cnt;
  logic                     phase_last;
  cam_bist_pkg::key_t       addr_key;
  cam_bist_pkg::cam_cmd_t   phase_cmd;

  assign addr_key = cam_bist_pkg::key_of(cam_bist_pkg::addr_t'(addr_cnt), AWIDTH, DWIDTH);

  // Walk takes three steps per address, other phases one
  assign phase_last = (addr_cnt == LAST_ADDR) && ((state != S_WALK) || (step == 2'd2));

  // ==================================================================
  // Command of the current phase
  // ==================================================================
  always_comb begin
    phase_cmd      = '0;
    phase_cmd.addr = cam_bist_pkg::addr_t'(addr_cnt);
    phase_cmd.key  = addr_key;
    next_phase     = S_IDLE;
    case (state)
      S_WR_KEY: begin
        phase_cmd.op = cam_bist_pkg::OP_WRITE;
        next_phase   = S_SRCH_KEY;
      end
      S_SRCH_KEY: begin
        phase_cmd.op        = cam_bist_pkg::OP_SEARCH;
        phase_cmd.cm_mode   = 1'b1;
        phase_cmd.match_sel = cam_bist_pkg::SEL_SINGLE_MATCH;
        next_phase          = S_RD_KEY;
      end
      S_RD_KEY: begin
        phase_cmd.op = cam_bist_pkg::OP_READ;
        // Compare-only stops after the read back
        next_phase   = (algo_q == cam_bist_pkg::ALGO_COMPARE) ? S_IDLE : S_WR_BG;
      end
      S_WR_BG: begin
        phase_cmd.op  = cam_bist_pkg::OP_WRITE;
        phase_cmd.key = KEY_BG;
        next_phase    = S_SRCH_BG;
      end
      S_SRCH_BG: begin
        phase_cmd.op      = cam_bist_pkg::OP_SEARCH;
        phase_cmd.key     = KEY_BG;
        phase_cmd.cm_mode = 1'b1;
        next_phase        = S_SRCH_INV;
      end
      S_SRCH_INV: begin
        phase_cmd.op        = cam_bist_pkg::OP_SEARCH;
        phase_cmd.key       = KEY_INV;
        phase_cmd.cm_mode   = 1'b1;
        phase_cmd.match_sel = cam_bist_pkg::SEL_ALL_MISMATCH;
        next_phase          = S_WALK;
      end
      S_WALK: begin
        // cm_mode held over the writes too, so the search result sees it
        phase_cmd.cm_mode   = 1'b1;
        phase_cmd.match_sel = cam_bist_pkg::SEL_SINGLE_MISMATCH;
        case (step)
          2'd0: begin
            phase_cmd.op  = cam_bist_pkg::OP_WRITE;
            phase_cmd.key = KEY_INV;
          end
          2'd1: begin
            phase_cmd.op  = cam_bist_pkg::OP_SEARCH;
            phase_cmd.key = KEY_BG;
          end
          default: begin
            // Restore the background at this address
            phase_cmd.op  = cam_bist_pkg::OP_WRITE;
            phase_cmd.key = KEY_BG;
          end
        endcase
      end
      default: begin
      end
    endcase
  end

  // ==================================================================
  // State, counters and the command register
  // ==================================================================
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      state       <= S_IDLE;
      after_gap   <= S_IDLE;
      algo_q      <= cam_bist_pkg::ALGO_MARCH;
      addr_cnt    <= '0;
      step        <= '0;
      gap_cnt     <= 1'b0;
      cmd         <= '0;
      busy        <= 1'b0;
      last_issued <= 1'b0;
    end else begin
      // Busy lags the state by one cycle to cover the trailing gap
      busy        <= (state != S_IDLE);
      last_issued <= 1'b0;
      case (state)
        S_IDLE: begin
          cmd.op <= cam_bist_pkg::OP_IDLE;
          if (bist_start && !busy) begin
            algo_q   <= algo;
            addr_cnt <= '0;
            step     <= '0;
            state    <= (algo == cam_bist_pkg::ALGO_COMPARE) ? S_SRCH_KEY : S_WR_KEY;
          end
        end
        S_GAP: begin
          // Idle op, select and mode kept from the last phase
          cmd.op  <= cam_bist_pkg::OP_IDLE;
          gap_cnt <= ~gap_cnt;
          if (gap_cnt) begin
            state <= after_gap;
          end
        end
        default: begin
          cmd <= phase_cmd;
          if (phase_last) begin
            addr_cnt    <= '0;
            step        <= '0;
            gap_cnt     <= 1'b0;
            after_gap   <= next_phase;
            state       <= S_GAP;
            last_issued <= (next_phase == S_IDLE);
          end else if ((state == S_WALK) && (step != 2'd2)) begin
            step <= step + 2'd1;
          end else begin
            step     <= '0;
            addr_cnt <= addr_cnt + 1'b1;
          end
        end
      endcase
    end
  end

endmodule

/* verilog/cam_array.sv */
// ====================================================================
// Behavioral binary CAM, one port
// Command registered in stage one, executed in stage two, so read
// data and match lines appear two cycles after the command
// Outputs keep their value until the next read or search
// Addresses at or above ENTRIES are ignored
// ====================================================================
`timescale 1ns/10ps

module cam_array #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH  = 12,
  parameter int AWIDTH  = 4
) (
  input  logic                   bist_clk,
  input  logic                   rst,
  input  cam_bist_pkg::cam_cmd_t cmd,
  output logic [ENTRIES-1:0]     match_lines,
  output logic [DWIDTH-1:0]      rd_data
);

  cam_bist_pkg::cam_cmd_t cmd_q;
  logic [DWIDTH-1:0]      mem [ENTRIES];
  logic [ENTRIES-1:0]     valid;
  logic [ENTRIES-1:0]     hits;
  logic [AWIDTH-1:0]      addr_q;
  logic [DWIDTH-1:0]      key_q;
  logic                   addr_ok;

  assign addr_q  = cmd_q.addr[AWIDTH-1:0];
  assign key_q   = cmd_q.key[DWIDTH-1:0];
  assign addr_ok = (int'(addr_q) < ENTRIES);

  // ==================================================================
  // Stage one, input register
  // ==================================================================
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      cmd_q <= '0;
    end else begin
      cmd_q <= cmd;
    end
  end

  // Full compare against every entry, invalid entries never hit
  always_comb begin
    for (int e = 0; e < ENTRIES; e++) begin
      hits[e] = valid[e] && (mem[e] == key_q);
    end
  end

  // ==================================================================
  // Stage two, write, read and search
  // ==================================================================
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      valid <= '0;
    end else if ((cmd_q.op == cam_bist_pkg::OP_WRITE) && addr_ok) begin
      valid[addr_q] <= 1'b1;
    end
  end

  always_ff @(posedge bist_clk) begin
    case (cmd_q.op)
      cam_bist_pkg::OP_WRITE: begin
        if (addr_ok) begin
          mem[addr_q] <= key_q;
        end
      end
      cam_bist_pkg::OP_READ: begin
        if (addr_ok) begin
          rd_data <= mem[addr_q];
        end
      end
      cam_bist_pkg::OP_SEARCH: begin
        match_lines <= hits;
      end
      default: begin
      end
    endcase
  end

endmodule

/* verilog/cam_bist_outhandler.sv */
// ====================================================================
// CAM BIST output handler
// Address is delayed two cycles to line up with the CAM outputs;
// cm_mode and match_sel are used as they come and must be held
// Fewer data bits than entries: entries fold modulo DWIDTH with OR
// More or equal: compare vector is zero padded at the top
// ====================================================================
`timescale 1ns/10ps

module cam_bist_outhandler #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH  = 12,
  parameter int AWIDTH  = 4
) (
  input  logic                     bist_clk,
  input  logic                     cm_mode,
  input  cam_bist_pkg::match_sel_e match_sel,
  input  logic [AWIDTH-1:0]        addr,
  input  logic [ENTRIES-1:0]       match_lines,
  input  logic [DWIDTH-1:0]        rd_data,
  output logic [DWIDTH-1:0]        rd_data_out,
  output logic [ENTRIES-1:0]       cm_match_ref
);

  logic [AWIDTH-1:0]  addr_q1;
  logic [AWIDTH-1:0]  addr_q2;
  logic [ENTRIES-1:0] single_ref;
  logic [ENTRIES-1:0] diff;
  logic [DWIDTH-1:0]  cm_cmp_data;

  // ==================================================================
  // Expected match vector
  // ==================================================================
  always_ff @(posedge bist_clk) begin
    addr_q1 <= addr;
    addr_q2 <= addr_q1;
  end

  // One-hot of the addressed entry
  assign single_ref = ENTRIES'(1) << addr_q2;

  always_comb begin
    case (match_sel)
      cam_bist_pkg::SEL_ALL_MATCH:       cm_match_ref = '1;
      cam_bist_pkg::SEL_SINGLE_MATCH:    cm_match_ref = single_ref;
      cam_bist_pkg::SEL_SINGLE_MISMATCH: cm_match_ref = ~single_ref;
      default:                           cm_match_ref = '0;
    endcase
  end

  // Any set bit is an entry that disagrees with the reference
  assign diff = cm_match_ref ^ match_lines;

  // ==================================================================
  // Compaction or expansion to data width
  // ==================================================================
  if (DWIDTH >= ENTRIES) begin : g_expand
    assign cm_cmp_data = DWIDTH'(diff);
  end else begin : g_compact
    always_comb begin
      cm_cmp_data = '0;
      // Entry e lands on bit e mod DWIDTH, the remainder wraps to the bottom
      for (int e = 0; e < ENTRIES; e++) begin
        cm_cmp_data[e % DWIDTH] = cm_cmp_data[e % DWIDTH] | diff[e];
      end
    end
  end

  // Compare result replaces read data in cm mode
  assign rd_data_out = cm_mode ? cm_cmp_data : rd_data;

endmodule

/* verilog/cam_bist_result.sv */
// ====================================================================
// CAM BIST result unit
// Checks only responses to commands issued while a run is active
// Search passes on all-zero compare data, read on the address key
// Fail flag is sticky and keeps the first failing address;
// both clear on an accepted start
// ====================================================================
`timescale 1ns/10ps

module cam_bist_result #(
  parameter int DWIDTH = 12,
  parameter int AWIDTH = 4
) (
  input  logic                   bist_clk,
  input  logic                   rst,
  input  logic                   bist_start,
  input  cam_bist_pkg::cam_cmd_t cmd,
  input  logic [DWIDTH-1:0]      check_data,
  input  logic                   last_issued,
  output logic                   done,
  output logic                   fail,
  output logic [AWIDTH-1:0]      fail_addr
);

  logic                  running;
  logic                  start_ok;
  cam_bist_pkg::cam_op_e op_q1;
  cam_bist_pkg::cam_op_e op_q2;
  logic [AWIDTH-1:0]     addr_q1;
  logic [AWIDTH-1:0]     addr_q2;
  logic                  bist_q1;
  logic                  bist_q2;
  logic                  last_q1;
  logic                  last_q2;
  cam_bist_pkg::key_t    exp_key;
  logic                  mismatch;

  assign start_ok = bist_start && !running;

  // ==================================================================
  // Two-stage pipeline matching the CAM latency
  // ==================================================================
  always_ff @(posedge bist_clk) begin
    op_q1   <= cmd.op;
    op_q2   <= op_q1;
    addr_q1 <= cmd.addr[AWIDTH-1:0];
    addr_q2 <= addr_q1;
  end

  always_ff @(posedge bist_clk) begin
    if (rst) begin
      bist_q1 <= 1'b0;
      bist_q2 <= 1'b0;
      last_q1 <= 1'b0;
      last_q2 <= 1'b0;
    end else begin
      // Commands seen during a run come from the sequencer
      bist_q1 <= running;
      bist_q2 <= bist_q1;
      last_q1 <= last_issued;
      last_q2 <= last_q1;
    end
  end

  // Read data must equal the key the March wrote or the preload held
  assign exp_key = cam_bist_pkg::key_of(cam_bist_pkg::addr_t'(addr_q2), AWIDTH, DWIDTH);

  always_comb begin
    mismatch = 1'b0;
    if (bist_q2) begin
      case (op_q2)
        cam_bist_pkg::OP_SEARCH: mismatch = |check_data;
        cam_bist_pkg::OP_READ:   mismatch = (check_data != exp_key[DWIDTH-1:0]);
        default:                 mismatch = 1'b0;
      endcase
    end
  end

  // ==================================================================
  // Run flag, done and sticky fail
  // ==================================================================
  always_ff @(posedge bist_clk) begin
    if (rst) begin
      running   <= 1'b0;
      done      <= 1'b0;
      fail      <= 1'b0;
      fail_addr <= '0;
    end else if (start_ok) begin
      running   <= 1'b1;
      done      <= 1'b0;
      fail      <= 1'b0;
      fail_addr <= '0;
    end else begin
      if (last_q2) begin
        running <= 1'b0;
        done    <= 1'b1;
      end
      // First failure only
      if (mismatch && !fail) begin
        fail      <= 1'b1;
        fail_addr <= addr_q2;
      end
    end
  end

endmodule

/* verilog/cam_bist_top.sv */
// ====================================================================
// CAM BIST subsystem top
// Functional port reaches the CAM only while bist_busy is low;
// functional commands during a run are dropped
// Functional searches use cm_mode off and the all-match reference
// AWIDTH and DWIDTH must fit the package bounds
// ====================================================================
`timescale 1ns/10ps

module cam_bist_top #(
  parameter int ENTRIES = 16,
  parameter int DWIDTH  = 12,
  parameter int AWIDTH  = 4
) (
  input  logic                     bist_clk,
  input  logic                     rst,
  input  logic                     bist_start,
  input  cam_bist_pkg::bist_algo_e algo,
  input  cam_bist_pkg::cam_op_e    fn_op,
  input  logic [AWIDTH-1:0]        fn_addr,
  input  logic [DWIDTH-1:0]        fn_key,
  output logic [DWIDTH-1:0]        rd_data_out,
  output logic [ENTRIES-1:0]       cm_match_ref,
  output logic                     bist_busy,
  output logic                     bist_done,
  output logic                     bist_fail,
  output logic [AWIDTH-1:0]        bist_fail_addr
);

  cam_bist_pkg::cam_cmd_t seq_cmd;
  cam_bist_pkg::cam_cmd_t fn_cmd;
  cam_bist_pkg::cam_cmd_t sel_cmd;
  logic                   last_issued;
  logic [ENTRIES-1:0]     match_lines;
  logic [DWIDTH-1:0]      cam_rd_data;

  // ==================================================================
  // Command mux
  // ==================================================================
  always_comb begin
    fn_cmd      = '0;
    fn_cmd.op   = fn_op;
    fn_cmd.addr = cam_bist_pkg::addr_t'(fn_addr);
    fn_cmd.key  = cam_bist_pkg::key_t'(fn_key);
  end

  assign sel_cmd = bist_busy ? seq_cmd : fn_cmd;

  cam_bist_sequencer #(
    .ENTRIES(ENTRIES),
    .DWIDTH (DWIDTH),
    .AWIDTH (AWIDTH)
  ) u_seq (
    .bist_clk   (bist_clk),
    .rst        (rst),
    .bist_start (bist_start),
    .algo       (algo),
    .cmd        (seq_cmd),
    .busy       (bist_busy),
    .last_issued(last_issued)
  );

  cam_array #(
    .ENTRIES(ENTRIES),
    .DWIDTH (DWIDTH),
    .AWIDTH (AWIDTH)
  ) u_cam (
    .bist_clk   (bist_clk),
    .rst        (rst),
    .cmd        (sel_cmd),
    .match_lines(match_lines),
    .rd_data    (cam_rd_data)
  );

  // Select and mode go in undelayed, the handler delays the address
  cam_bist_outhandler #(
    .ENTRIES(ENTRIES),
    .DWIDTH (DWIDTH),
    .AWIDTH (AWIDTH)
  ) u_outh (
    .bist_clk    (bist_clk),
    .cm_mode     (sel_cmd.cm_mode),
    .match_sel   (sel_cmd.match_sel),
    .addr        (sel_cmd.addr[AWIDTH-1:0]),
    .match_lines (match_lines),
    .rd_data     (cam_rd_data),
    .rd_data_out (rd_data_out),
    .cm_match_ref(cm_match_ref)
  );

  cam_bist_result #(
    .DWIDTH(DWIDTH),
    .AWIDTH(AWIDTH)
  ) u_res (
    .bist_clk   (bist_clk),
    .rst        (rst),
    .bist_start (bist_start),
    .cmd        (sel_cmd),
    .check_data (rd_data_out),
    .last_issued(last_issued),
    .done       (bist_done),
    .fail       (bist_fail),
    .fail_addr  (bist_fail_addr)
  );

endmodule

/* test/tb_cam_bist.sv */
// ====================================================================
// Testbench for the CAM BIST subsystem, default parameters only
// Inputs change 1 ns after the rising edge, outputs sampled there too
// Expected keys put the address low and its inverse above it
// Every wait on bist_done is bounded by DONE_TIMEOUT cycles
// ====================================================================
`timescale 1ns/10ps

module tb_cam_bist;

  localparam int ENTRIES      = 16;
  localparam int DWIDTH       = 12;
  localparam int AWIDTH       = 4;
  localparam int DONE_TIMEOUT = 2000;

  logic                     bist_clk;
  logic                     rst;
  logic                     bist_start;
  cam_bist_pkg::bist_algo_e algo;
  cam_bist_pkg::cam_op_e    fn_op;
  logic [AWIDTH-1:0]        fn_addr;
  logic [DWIDTH-1:0]        fn_key;
  logic [DWIDTH-1:0]        rd_data_out;
  logic [ENTRIES-1:0]       cm_match_ref;
  logic                     bist_busy;
  logic                     bist_done;
  logic                     bist_fail;
  logic [AWIDTH-1:0]        bist_fail_addr;

  logic [31:0]       rng;
  logic [DWIDTH-1:0] written [ENTRIES];
  logic [AWIDTH-1:0] bad_addr;
  logic [DWIDTH-1:0] bad_key;
  string             cur_name;
  int                checks;
  int                errors;
  int                test_checks;
  int                test_errors;

  cam_bist_top #(
    .ENTRIES(ENTRIES),
    .DWIDTH (DWIDTH),
    .AWIDTH (AWIDTH)
  ) uut (
    .bist_clk      (bist_clk),
    .rst           (rst),
    .bist_start    (bist_start),
    .algo          (algo),
    .fn_op         (fn_op),
    .fn_addr       (fn_addr),
    .fn_key        (fn_key),
    .rd_data_out   (rd_data_out),
    .cm_match_ref  (cm_match_ref),
    .bist_busy     (bist_busy),
    .bist_done     (bist_done),
    .bist_fail     (bist_fail),
    .bist_fail_addr(bist_fail_addr)
  );

  // 8 ns period
  initial bist_clk = 1'b0;
  always #4 bist_clk = ~bist_clk;

  // ==================================================================
  // Helpers
  // ==================================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Address at the bottom, inverted address copied upward
  function automatic logic [DWIDTH-1:0] address_key(input logic [AWIDTH-1:0] a);
    logic [AWIDTH-1:0]        inv;
    logic [DWIDTH+AWIDTH-1:0] wide;
    inv  = ~a;
    wide = (DWIDTH + AWIDTH)'(a);
    for (int k = 1; k * AWIDTH < DWIDTH; k++) begin
      wide = wide | ((DWIDTH + AWIDTH)'(inv) << (k * AWIDTH));
    end
    return wide[DWIDTH-1:0];
  endfunction

  function automatic logic is_address_key(input logic [DWIDTH-1:0] v);
    logic hit;
    hit = 1'b0;
    for (int a = 0; a < ENTRIES; a++) begin
      hit = hit | (v == address_key(AWIDTH'(a)));
    end
    return hit;
  endfunction

  task automatic step_cycle();
    @(posedge bist_clk);
    #1;
  endtask

  // One functional command, held for one cycle
  task automatic drive_cmd(input cam_bist_pkg::cam_op_e op, input logic [AWIDTH-1:0] a,
                           input logic [DWIDTH-1:0] k);
    step_cycle();
    fn_op   = op;
    fn_addr = a;
    fn_key  = k;
  endtask

  task automatic count_error();
    errors++;
    test_errors++;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp,
                             input logic [31:0] act);
    checks++;
    test_checks++;
    assert (act == exp) else begin
      $display("ERR %s %s expected %h actual %h", cur_name, what, exp, act);
      count_error();
    end
  endtask

  task automatic begin_test(input string name);
    cur_name    = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("%-14s %0d checks, %0d errors", cur_name, test_checks, test_errors);
  endtask

  // Read data shows up two cycles after the read command
  task automatic read_and_check(input logic [AWIDTH-1:0] a, input logic [DWIDTH-1:0] exp);
    drive_cmd(cam_bist_pkg::OP_READ, a, '0);
    drive_cmd(cam_bist_pkg::OP_IDLE, '0, '0);
    step_cycle();
    check_value($sformatf("rd_data_out[%0d]", a), 32'(exp), 32'(rd_data_out));
  endtask

  // Start pulse, then wait for done with a bound
  task automatic run_bist(input cam_bist_pkg::bist_algo_e sel);
    int   cycles;
    logic saw_busy;
    cycles   = 0;
    saw_busy = 1'b0;
    step_cycle();
    algo       = sel;
    bist_start = 1'b1;
    step_cycle();
    bist_start = 1'b0;
    while (!bist_done && cycles < DONE_TIMEOUT) begin
      saw_busy = saw_busy | bist_busy;
      step_cycle();
      cycles++;
    end
    checks += 2;
    test_checks += 2;
    assert (bist_done) else begin
      $display("%s: bist_done did not rise within %0d cycles", cur_name, DONE_TIMEOUT);
      count_error();
    end
    assert (saw_busy) else begin
      $display("%s: bist_busy never went high during the run", cur_name);
      count_error();
    end
  endtask

  // ==================================================================
  // Test sequence
  // ==================================================================
  initial begin
    rst        = 1'b1;
    bist_start = 1'b0;
    algo       = cam_bist_pkg::ALGO_MARCH;
    fn_op      = cam_bist_pkg::OP_IDLE;
    fn_addr    = '0;
    fn_key     = '0;
    rng        = 32'h5775;
    checks     = 0;
    errors     = 0;
    repeat (10) @(posedge bist_clk);
    #1;
    rst = 1'b0;

    begin_test("reset");
    check_value("bist_busy", 32'd0, 32'(bist_busy));
    check_value("bist_done", 32'd0, 32'(bist_done));
    check_value("bist_fail", 32'd0, 32'(bist_fail));
    end_test();

    // Random keys through the functional port
    begin_test("functional");
    for (int a = 0; a < ENTRIES; a++) begin
      rng        = xorshift32(rng);
      written[a] = rng[DWIDTH-1:0];
      drive_cmd(cam_bist_pkg::OP_WRITE, AWIDTH'(a), written[a]);
    end
    drive_cmd(cam_bist_pkg::OP_IDLE, '0, '0);
    for (int a = 0; a < ENTRIES; a++) begin
      read_and_check(AWIDTH'(a), written[a]);
    end
    // Functional searches keep the all-match reference
    for (int a = 0; a < ENTRIES; a++) begin
      drive_cmd(cam_bist_pkg::OP_SEARCH, '0, written[a]);
      drive_cmd(cam_bist_pkg::OP_IDLE, '0, '0);
      check_value("cm_match_ref", 32'(ENTRIES'('1)), 32'(cm_match_ref));
    end
    end_test();

    begin_test("march");
    run_bist(cam_bist_pkg::ALGO_MARCH);
    check_value("bist_fail", 32'd0, 32'(bist_fail));
    end_test();

    // Preload address keys, then corrupt one entry
    begin_test("corrupt");
    for (int a = 0; a < ENTRIES; a++) begin
      drive_cmd(cam_bist_pkg::OP_WRITE, AWIDTH'(a), address_key(AWIDTH'(a)));
    end
    rng      = xorshift32(rng);
    bad_addr = rng[AWIDTH-1:0];
    bad_key  = address_key(bad_addr);
    while (is_address_key(bad_key)) begin
      rng     = xorshift32(rng);
      bad_key = rng[DWIDTH-1:0];
    end
    drive_cmd(cam_bist_pkg::OP_WRITE, bad_addr, bad_key);
    drive_cmd(cam_bist_pkg::OP_IDLE, '0, '0);
    run_bist(cam_bist_pkg::ALGO_COMPARE);
    check_value("bist_fail", 32'd1, 32'(bist_fail));
    check_value("bist_fail_addr", 32'(bad_addr), 32'(bist_fail_addr));
    end_test();

    // Repair the entry, start must also clear the sticky flag and address
    begin_test("compare_clean");
    drive_cmd(cam_bist_pkg::OP_WRITE, bad_addr, address_key(bad_addr));
    drive_cmd(cam_bist_pkg::OP_IDLE, '0, '0);
    run_bist(cam_bist_pkg::ALGO_COMPARE);
    check_value("bist_fail", 32'd0, 32'(bist_fail));
    check_value("bist_fail_addr", 32'd0, 32'(bist_fail_addr));
    end_test();

    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* verilog.f */
verilog/cam_bist_pkg.sv
verilog/cam_bist_sequencer.sv
verilog/cam_array.sv
verilog/cam_bist_outhandler.sv
verilog/cam_bist_result.sv
verilog/cam_bist_top.sv
test/tb_cam_bist.sv

/* run_sim.sh */
#!/bin/bash
# Build and run the CAM BIST testbench with Verilator
# Exit status is nonzero when the log holds the fail message

set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_cam_bist \
  -f verilog.f \
  -o tb_cam_bist

./obj_dir/tb_cam_bist 2>&1 | tee sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
exit 0
